// File: design/ipv4_fwd_pkg.sv
/* Widths, header byte offsets, beat and status structs, beat index type
   and the ones' complement adder shared by the IPv4 forwarding stages */

package ipv4_fwd_pkg;

    ////////////////////////////////////////
    // Widths

    localparam int beat_bytes = 8;
    localparam int data_w     = beat_bytes * 8;
    localparam int csum_w     = 16;
    localparam int idx_w      = 3;

    typedef logic [data_w-1:0]     data_t;
    typedef logic [beat_bytes-1:0] keep_t;
    typedef logic [idx_w-1:0]      beat_idx_t;
    typedef logic [csum_w-1:0]     csum_t;

    // Beat counter stops here on long packets
    localparam beat_idx_t beat_idx_max = '1;

    ////////////////////////////////////////
    // Frame layout, byte offsets from start of packet

    localparam int ethertype_offset = 12;
    localparam int ipv4_hdr_offset  = 14;
    localparam int ipv4_hdr_bytes   = 20;
    localparam int ttl_offset       = 22;
    localparam int chk_offset       = 24;

    // Beats that carry the fields above
    localparam beat_idx_t ethertype_beat = beat_idx_t'(ethertype_offset / beat_bytes);
    localparam beat_idx_t ttl_beat       = beat_idx_t'(ttl_offset / beat_bytes);
    localparam beat_idx_t chk_beat       = beat_idx_t'(chk_offset / beat_bytes);
    localparam beat_idx_t hdr_end_beat   =
        beat_idx_t'((ipv4_hdr_offset + ipv4_hdr_bytes - 1) / beat_bytes);

    localparam csum_t ipv4_ethertype = 16'h0800;

    ////////////////////////////////////////
    // Stream types

    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;
    } pkt_beat_t;

    typedef struct packed {
        pkt_beat_t beat;
        beat_idx_t idx;
        logic      is_ipv4;
    } tagged_beat_t;

    // Only nonzero on the last beat of a packet
    typedef struct packed {
        logic hdr_bad;
        logic ttl_zero;
    } pkt_status_t;

    // 16-bit add with end-around carry
    function automatic csum_t csum_add(input csum_t a, input csum_t b);
        logic [csum_w:0] s;
        s = {1'b0, a} + {1'b0, b};
        return s[csum_w-1:0] + csum_t'(s[csum_w]);
    endfunction

endpackage

// File: design/eth_beat_indexer.sv
/* First pipeline stage: beat numbering within a packet and
   IPv4 detection from the EtherType */

module eth_beat_indexer import ipv4_fwd_pkg::*; (
    input  logic         core_clk_ifc,
    input  logic         reset,

    input  pkt_beat_t    in_beat,
    input  logic         in_valid,
    output logic         in_ready,

    output tagged_beat_t tag_beat,
    output logic         tag_valid,
    input  logic         tag_ready
);

    // Bit position of the EtherType inside its beat, byte 0 at the top
    localparam int ethertype_msb = data_w - 1 - 8 * (ethertype_offset % beat_bytes);

    beat_idx_t cnt_q;
    logic      is_ipv4_q;
    logic      eth_match;
    logic      cur_ipv4;
    logic      accept;

    assign in_ready = !tag_valid || tag_ready;
    assign accept   = in_valid && in_ready;

    assign eth_match = (in_beat.data[ethertype_msb -: csum_w] == ipv4_ethertype);

    // Beat 1 uses the compare directly, later beats the held flag
    assign cur_ipv4 = (cnt_q == ethertype_beat) ? eth_match : is_ipv4_q;

    ////////////////////////////////////////
    // Packet position tracking

    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            cnt_q     <= '0;
            is_ipv4_q <= 1'b0;
        end else if (accept) begin
            if (in_beat.last) begin
                cnt_q     <= '0;
                is_ipv4_q <= 1'b0;
            end else begin
                if (cnt_q != beat_idx_max) begin
                    cnt_q <= cnt_q + 1'b1;
                end
                is_ipv4_q <= cur_ipv4;
            end
        end
    end

    ////////////////////////////////////////
    // Output register

    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            tag_valid <= 1'b0;
        end else if (accept) begin
            tag_valid <= 1'b1;
        end else if (tag_ready) begin
            tag_valid <= 1'b0;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (accept) begin
            tag_beat.beat    <= in_beat;
            tag_beat.idx     <= cnt_q;
            tag_beat.is_ipv4 <= cur_ipv4;
        end
    end

endmodule

// File: design/ipv4_hdr_verify.sv
/* Second pipeline stage: ones' complement sum over the IPv4 header
   and the checksum-bad flag on the last beat */

module ipv4_hdr_verify import ipv4_fwd_pkg::*; (
    input  logic         core_clk_ifc,
    input  logic         reset,

    input  tagged_beat_t in_tag,
    input  logic         in_valid,
    output logic         in_ready,

    output tagged_beat_t out_tag,
    output pkt_status_t  out_status,
    output logic         out_valid,
    input  logic         out_ready
);

    localparam int words_per_beat = beat_bytes / 2;
    localparam int hdr_last_byte  = ipv4_hdr_offset + ipv4_hdr_bytes - 1;

    csum_t       sum_q;
    csum_t       sum_next;
    pkt_status_t status_next;
    logic        accept;

    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    ////////////////////////////////////////
    // Header sum

    // Adds every 16-bit word of this beat that falls inside bytes 14..33
    always_comb begin
        int byte_pos;
        sum_next = sum_q;
        for (int w = 0; w < words_per_beat; w++) begin
            byte_pos = int'(in_tag.idx) * beat_bytes + 2 * w;
            if (in_tag.is_ipv4 && in_tag.idx <= hdr_end_beat &&
                byte_pos >= ipv4_hdr_offset && byte_pos <= hdr_last_byte) begin
                sum_next = csum_add(sum_next,
                                    in_tag.beat.data[data_w-1-csum_w*w -: csum_w]);
            end
        end
    end

    // Good header folds to all ones
    always_comb begin
        status_next = '0;
        if (in_tag.beat.last) begin
            status_next.hdr_bad = in_tag.is_ipv4 && (sum_next != 16'hFFFF);
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            sum_q <= '0;
        end else if (accept) begin
            if (in_tag.beat.last) begin
                sum_q <= '0;
            end else begin
                sum_q <= sum_next;
            end
        end
    end

    ////////////////////////////////////////
    // Output register

    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (accept) begin
            out_tag    <= in_tag;
            out_status <= status_next;
        end
    end

endmodule

// File: design/ipv4_ttl_rewrite.sv
/* Third pipeline stage: TTL decrement, incremental checksum update
   and the TTL-zero flag */

module ipv4_ttl_rewrite import ipv4_fwd_pkg::*; (
    input  logic         core_clk_ifc,
    input  logic         reset,

    input  tagged_beat_t in_tag,
    input  pkt_status_t  in_status,
    input  logic         in_valid,
    output logic         in_ready,

    output pkt_beat_t    out_beat,
    output pkt_status_t  out_status,
    output logic         out_valid,
    input  logic         out_ready
);

    // Field positions inside their beats, byte 0 at the top
    localparam int ttl_msb = data_w - 1 - 8 * (ttl_offset % beat_bytes);
    localparam int chk_msb = data_w - 1 - 8 * (chk_offset % beat_bytes);

    csum_t       old_word_q;
    csum_t       new_word_q;
    logic        ttl_zero_q;

    csum_t       old_word;
    csum_t       new_word;
    csum_t       old_chk;
    csum_t       new_chk;
    logic        ttl_beat_hit;
    logic        chk_beat_hit;
    logic        accept;
    pkt_beat_t   beat_next;
    pkt_status_t status_next;

    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    assign ttl_beat_hit = in_tag.is_ipv4 && (in_tag.idx == ttl_beat);
    assign chk_beat_hit = in_tag.is_ipv4 && (in_tag.idx == chk_beat);

    ////////////////////////////////////////
    // Field rewrite

    assign old_word = in_tag.beat.data[ttl_msb -: csum_w];
    assign old_chk  = in_tag.beat.data[chk_msb -: csum_w];

    // TTL sits in the high byte, protocol in the low byte
    assign new_word = (old_word[15:8] == 8'd0) ?
                      old_word : {old_word[15:8] - 8'd1, old_word[7:0]};

    // RFC 1624 form, HC' = ~(~HC + ~m + m')
    assign new_chk = ~csum_add(csum_add(~old_chk, ~old_word_q), new_word_q);

    always_comb begin
        beat_next = in_tag.beat;
        if (ttl_beat_hit) begin
            beat_next.data[ttl_msb -: csum_w] = new_word;
        end
        // Zero TTL leaves the checksum as it came in
        if (chk_beat_hit && !ttl_zero_q) begin
            beat_next.data[chk_msb -: csum_w] = new_chk;
        end
    end

    always_comb begin
        status_next = '0;
        if (in_tag.beat.last) begin
            status_next.hdr_bad  = in_status.hdr_bad;
            status_next.ttl_zero = ttl_zero_q;
        end
    end

    ////////////////////////////////////////
    // Per-packet state

    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            ttl_zero_q <= 1'b0;
        end else if (accept) begin
            if (in_tag.beat.last) begin
                ttl_zero_q <= 1'b0;
            end else if (ttl_beat_hit) begin
                ttl_zero_q <= (old_word[15:8] == 8'd0);
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (accept && ttl_beat_hit) begin
            old_word_q <= old_word;
            new_word_q <= new_word;
        end
    end

    ////////////////////////////////////////
    // Output register

    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (accept) begin
            out_beat   <= beat_next;
            out_status <= status_next;
        end
    end

endmodule

// File: design/ipv4_fwd_top.sv
/* IPv4 forwarding stage: indexer, header verify and TTL rewrite
   chained as a three-register pipeline */

module ipv4_fwd_top import ipv4_fwd_pkg::*; (
    input  logic        core_clk_ifc,
    input  logic        reset,

    input  pkt_beat_t   in_beat,
    input  logic        in_valid,
    output logic        in_ready,

    output pkt_beat_t   out_beat,
    output pkt_status_t out_status,
    output logic        out_valid,
    input  logic        out_ready
);

    // Indexer to verifier
    tagged_beat_t idx_tag;
    logic         idx_valid;
    logic         idx_ready;

    // Verifier to rewriter
    tagged_beat_t ver_tag;
    pkt_status_t  ver_status;
    logic         ver_valid;
    logic         ver_ready;

    eth_beat_indexer u_indexer (
        .core_clk_ifc (core_clk_ifc),
        .reset        (reset),
        .in_beat      (in_beat),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .tag_beat     (idx_tag),
        .tag_valid    (idx_valid),
        .tag_ready    (idx_ready)
    );

    ipv4_hdr_verify u_verify (
        .core_clk_ifc (core_clk_ifc),
        .reset        (reset),
        .in_tag       (idx_tag),
        .in_valid     (idx_valid),
        .in_ready     (idx_ready),
        .out_tag      (ver_tag),
        .out_status   (ver_status),
        .out_valid    (ver_valid),
        .out_ready    (ver_ready)
    );

    ipv4_ttl_rewrite u_rewrite (
        .core_clk_ifc (core_clk_ifc),
        .reset        (reset),
        .in_tag       (ver_tag),
        .in_status    (ver_status),
        .in_valid     (ver_valid),
        .in_ready     (ver_ready),
        .out_beat     (out_beat),
        .out_status   (out_status),
        .out_valid    (out_valid),
        .out_ready    (out_ready)
    );

endmodule

// File: sim/ipv4_fwd_properties.sv
/* Output handshake and status assertions, bound to the forwarding top level */

module ipv4_fwd_properties import ipv4_fwd_pkg::*; (
    input logic        core_clk_ifc,
    input logic        reset,
    input pkt_beat_t   out_beat,
    input pkt_status_t out_status,
    input logic        out_valid,
    input logic        out_ready
);

    // Output register comes out of reset empty
    idle_after_reset: assert property (
        @(posedge core_clk_ifc) reset |=> !out_valid
    ) else $error("out_valid high in the cycle after reset");

    // A stalled beat stays put until it is taken
    hold_while_stalled: assert property (
        @(posedge core_clk_ifc) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_beat) && $stable(out_status)
    ) else $error("output beat changed while stalled");

    status_on_last_only: assert property (
        @(posedge core_clk_ifc) disable iff (reset)
        out_valid && !out_beat.last |-> out_status == '0
    ) else $error("out_status nonzero on a beat that is not last");

endmodule

bind ipv4_fwd_top ipv4_fwd_properties u_properties (
    .core_clk_ifc (core_clk_ifc),
    .reset        (reset),
    .out_beat     (out_beat),
    .out_status   (out_status),
    .out_valid    (out_valid),
    .out_ready    (out_ready)
);

// File: sim/ipv4_fwd_tb.sv
/* IPv4 forwarding testbench with golden-file beats, steady and
   back-pressured passes, latency, drain and per-packet checks */

module ipv4_fwd_tb import ipv4_fwd_pkg::*; ();

    localparam int    num_beats      = 33;
    localparam int    words_per_beat = 4;
    localparam int    num_words      = num_beats * words_per_beat;
    localparam int    pass_timeout   = 2000;
    localparam int    pipe_latency   = 3;
    localparam string golden_path    = "sim/ipv4_fwd_golden.txt";

    logic        core_clk_ifc;
    logic        reset;
    pkt_beat_t   in_beat;
    logic        in_valid;
    logic        in_ready;
    pkt_beat_t   out_beat;
    pkt_status_t out_status;
    logic        out_valid;
    logic        out_ready;

    // Four words per beat in golden file column order
    logic [63:0] golden_mem [0:num_words-1];
    string       pkt_names [4] = '{"ipv4_ttl_decrement", "ipv4_bad_checksum",
                                   "non_ipv4_passthrough", "ipv4_ttl_zero"};
    logic [31:0] rng_state;
    int          error_count;
    int          test_count;
    int          test_fails;
    bit          run_aborted;

    ipv4_fwd_top DUT (
        .core_clk_ifc (core_clk_ifc),
        .reset        (reset),
        .in_beat      (in_beat),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .out_beat     (out_beat),
        .out_status   (out_status),
        .out_valid    (out_valid),
        .out_ready    (out_ready)
    );

    always #10 core_clk_ifc = ~core_clk_ifc;

    ////////////////////////////////////////
    // Helpers

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic pkt_beat_t golden_in_beat(input int i);
        pkt_beat_t b;
        b.data = golden_mem[i*words_per_beat];
        b.keep = golden_mem[i*words_per_beat+1][11:4];
        b.last = golden_mem[i*words_per_beat+1][0];
        return b;
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, actual, expected);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s: pass", name);
        end else begin
            test_fails++;
            $display("test %s: fail with %0d errors", name, error_count - errors_before);
        end
    endtask

    ////////////////////////////////////////
    // One pass over the golden stream

    task automatic run_pass(input bit stalled, input string label);
        int          send_idx;
        int          recv_idx;
        int          cycles;
        int          pkt_num;
        int          pkt_errors;
        int          in_edge;
        int          out_edge;
        bit          in_fire;
        bit          out_fire;
        logic [63:0] ctrl;

        send_idx   = 1;
        recv_idx   = 0;
        cycles     = 0;
        pkt_num    = 0;
        pkt_errors = error_count;
        in_edge    = -1;
        out_edge   = -1;

        @(posedge core_clk_ifc);
        in_beat   <= golden_in_beat(0);
        in_valid  <= 1'b1;
        out_ready <= 1'b1;

        while (recv_idx < num_beats && cycles < pass_timeout) begin
            // Sample mid-cycle, ahead of the transfer edge
            @(negedge core_clk_ifc);
            in_fire  = in_valid && in_ready;
            out_fire = out_valid && out_ready;
            if (in_fire && in_edge < 0) begin
                in_edge = cycles;
            end
            if (out_fire) begin
                ctrl = golden_mem[recv_idx*words_per_beat+1];
                if (out_edge < 0) begin
                    out_edge = cycles;
                end
                check_value("out_beat.data", out_beat.data,
                            golden_mem[recv_idx*words_per_beat+2]);
                check_value("out_beat.keep", 64'(out_beat.keep), 64'(ctrl[11:4]));
                check_value("out_beat.last", 64'(out_beat.last), 64'(ctrl[0]));
                check_value("out_status", 64'(out_status),
                            golden_mem[recv_idx*words_per_beat+3]);
                recv_idx++;
                if (ctrl[0]) begin
                    report_test({label, " ", pkt_names[pkt_num]}, pkt_errors);
                    pkt_errors = error_count;
                    pkt_num++;
                end
            end
            @(posedge core_clk_ifc);
            cycles++;
            rng_state = xorshift32(rng_state);
            // New beat only once the held one has gone
            if (in_fire || !in_valid) begin
                if (send_idx < num_beats && (!stalled || rng_state[0])) begin
                    in_beat  <= golden_in_beat(send_idx);
                    in_valid <= 1'b1;
                    send_idx++;
                end else begin
                    in_valid <= 1'b0;
                end
            end
            out_ready <= !stalled || (rng_state[3:2] != 2'b00);
        end

        in_valid  <= 1'b0;
        out_ready <= 1'b1;
        if (recv_idx < num_beats) begin
            $display("Timeout: %s pass got only %0d of %0d beats within %0d cycles",
                     label, recv_idx, num_beats, pass_timeout);
            error_count++;
            run_aborted = 1'b1;
        end else begin
            if (!stalled) begin
                check_value("first beat latency", 64'(out_edge - in_edge),
                            64'(pipe_latency));
                report_test({label, " latency"}, pkt_errors);
                pkt_errors = error_count;
            end
            // No beat may leave once the whole stream is out
            for (int c = 0; c <= pipe_latency; c++) begin
                @(negedge core_clk_ifc);
                check_value("out_valid", 64'(out_valid), 64'd0);
            end
            report_test({label, " no_extra_beats"}, pkt_errors);
        end
    endtask

    ////////////////////////////////////////
    // Main sequence

    initial begin
        core_clk_ifc = 1'b0;
        reset        = 1'b1;
        in_beat      = '0;
        in_valid     = 1'b0;
        out_ready    = 1'b0;
        rng_state    = 32'd16;
        error_count  = 0;
        test_count   = 0;
        test_fails   = 0;
        run_aborted  = 1'b0;

        $readmemh(golden_path, golden_mem);
        if ($isunknown(golden_mem[num_words-1])) begin
            $display("Golden file %s holds fewer than %0d beats", golden_path, num_beats);
            error_count++;
            run_aborted = 1'b1;
        end

        repeat (10) @(posedge core_clk_ifc);
        reset <= 1'b0;

        if (!run_aborted) begin
            run_pass(1'b0, "steady");
        end
        if (!run_aborted) begin
            run_pass(1'b1, "stalled");
        end

        $display("Summary: %0d tests, %0d failed, %0d errors",
                 test_count, test_fails, error_count);
        if (error_count == 0 && test_fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: sim/ipv4_fwd_golden.txt
// Columns: input data, keep_last, expected output data, expected status
// keep_last holds keep in bits 11:4 and last in bit 0, status is {hdr_bad, ttl_zero}
// IPv4, TTL 0x40, good checksum
001a2b3c4d5e0011 ff0 001a2b3c4d5e0011 0
2233445508004500 ff0 2233445508004500 0
003c1c4640004006 ff0 003c1c4640003f06 0
b1e6ac100a63ac10 ff0 b2e6ac100a63ac10 0
0a0c000102030405 ff0 0a0c000102030405 0
060708090a0b0c0d ff0 060708090a0b0c0d 0
0e0f101112131415 ff0 0e0f101112131415 0
161718191a1b1c1d ff1 161718191a1b1c1d 0
// IPv4, TTL 0x80, checksum off by one
02aabbccddee0066 ff0 02aabbccddee0066 0
7788990008004500 ff0 7788990008004500 0
003c1c4740008011 ff0 003c1c4740007f11 0
5c52c0a80001c0a8 ff0 5d52c0a80001c0a8 0
00c7a0a1a2a3a4a5 ff0 00c7a0a1a2a3a4a5 0
a6a7a8a9aaabacad ff0 a6a7a8a9aaabacad 0
aeafb0b1b2b3b4b5 ff0 aeafb0b1b2b3b4b5 0
b6b7b8b9babbbcbd ff1 b6b7b8b9babbbcbd 2
// ARP, nine beats, partial keep on the last
ffffffffffff0010 ff0 ffffffffffff0010 0
2030405008060001 ff0 2030405008060001 0
0800060400010010 ff0 0800060400010010 0
203040500a000001 ff0 203040500a000001 0
0000000000000a00 ff0 0000000000000a00 0
0002000000000000 ff0 0002000000000000 0
1111111111111111 ff0 1111111111111111 0
2222222222222222 ff0 2222222222222222 0
c0ffee0000000000 f01 c0ffee0000000000 0
// IPv4, TTL zero
3c4d5e6f70810092 ff0 3c4d5e6f70810092 0
a3b4c5d608004500 ff0 a3b4c5d608004500 0
003c000100000001 ff0 003c000100000001 0
a6be0a0000010a00 ff0 a6be0a0000010a00 0
0002fefdfcfbfaf9 ff0 0002fefdfcfbfaf9 0
f8f7f6f5f4f3f2f1 ff0 f8f7f6f5f4f3f2f1 0
f0efeeedecebeae9 ff0 f0efeeedecebeae9 0
e8e7e6e5e4e3e2e1 ff1 e8e7e6e5e4e3e2e1 1

// File: filelist.f
design/ipv4_fwd_pkg.sv
design/eth_beat_indexer.sv
design/ipv4_hdr_verify.sv
design/ipv4_ttl_rewrite.sv
design/ipv4_fwd_top.sv
sim/ipv4_fwd_properties.sv
sim/ipv4_fwd_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the IPv4 forwarding testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --assert --top-module ipv4_fwd_tb -Mdir "$build_dir" -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/Vipv4_fwd_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" "$log_file"; then
    echo "Simulation reported failure, see $log_file"
    exit 1
fi

exit 0
